/* logic/board_audio_pkg.sv */
package board_audio_pkg;

    //----------------------------------------------------------
    // Sample widths

    localparam int w_mic_sample  = 24;  // INMP441 data word
    localparam int w_sound       = 16;  // Output word to the I2S DAC

    //----------------------------------------------------------
    // I2S frame shape, shared by microphone and output sides

    // clk cycles per half period of sck and bclk
    localparam int i2s_half_bit_clks = 4;

    localparam int mic_slot_bits = 32;  // Bits per ws half frame
    localparam int out_slot_bits = 16;  // Bits per lrclk half frame

    //----------------------------------------------------------
    // Level bar

    localparam int led_bar_width = 6;

    // Lowest LED lights at a peak of 2 ** led_base_bit
    localparam int led_base_bit  = 9;

    //----------------------------------------------------------
    // Types

    typedef logic signed [w_mic_sample  - 1:0] mic_sample_t;
    typedef logic signed [w_sound       - 1:0] sound_t;
    typedef logic        [led_bar_width - 1:0] led_bar_t;

endpackage

/* logic/decay_strobe_gen.sv */
`timescale 1ns/1ps

module decay_strobe_gen
#(
    parameter clk_mhz = 27,
              tick_hz = 2
)
(
    input  logic clk,
    input  logic reset,
    output logic decay_tick
);

    localparam int period = clk_mhz * 1000 * 1000 / tick_hz;
    localparam int w_cnt  = period > 1 ? $clog2 (period) : 1;

    logic [w_cnt - 1:0] cnt;

    // One pulse per period, a clock enable rather than a slow clock
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt        <= '0;
            decay_tick <= 1'b0;
        end
        else if (cnt == w_cnt' (period - 1))
        begin
            cnt        <= '0;
            decay_tick <= 1'b1;
        end
        else
        begin
            cnt        <= cnt + 1'b1;
            decay_tick <= 1'b0;
        end
    end

endmodule

/* logic/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sd,

    output logic                         sck,
    output logic                         ws,

    output board_audio_pkg::mic_sample_t value,
    output logic                         value_valid
);

    import board_audio_pkg::*;

    //----------------------------------------------------------
    // Phase counter layout, LSB first
    //   half bit count, sck, bit position in slot, ws

    localparam int w_half  = $clog2 (i2s_half_bit_clks);
    localparam int w_bit   = $clog2 (mic_slot_bits);
    localparam int w_phase = w_half + 1 + w_bit + 1;

    logic [w_phase - 1:0] phase;
    logic [w_bit   - 1:0] bit_pos;

    logic        sck_rise;
    logic        take_bit;
    logic        last_bit;
    mic_sample_t shift;

    always_ff @(posedge clk)
    begin
        if (reset)
            phase <= '0;
        else
            phase <= phase + 1'b1;
    end

    assign sck     = phase [w_half];
    assign ws      = phase [w_phase - 1];  // Low for the left slot
    assign bit_pos = phase [w_half + 1 +: w_bit];

    // Edge on which sck goes high
    assign sck_rise = phase [w_half:0] == (w_half + 1)' (i2s_half_bit_clks - 1);

    //----------------------------------------------------------
    // Left slot data, bit positions 1 to 24, MSB first

    assign take_bit = sck_rise & ~ ws
                    & bit_pos != '0
                    & bit_pos <= w_bit' (w_mic_sample);

    assign last_bit = take_bit & bit_pos == w_bit' (w_mic_sample);

    always_ff @(posedge clk)
    begin
        if (take_bit)
            shift <= { shift [w_mic_sample - 2:0], sd };
    end

    // Whole word goes out together with the final bit
    always_ff @(posedge clk)
    begin
        if (last_bit)
            value <= { shift [w_mic_sample - 2:0], sd };
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            value_valid <= 1'b0;
        else
            value_valid <= last_bit;
    end

endmodule

/* logic/level_meter_lab.sv */
`timescale 1ns/1ps

module level_meter_lab
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic [1:0]                   lab_key,

    input  board_audio_pkg::mic_sample_t mic_value,
    input  logic                         mic_valid,
    input  logic                         decay_tick,

    output board_audio_pkg::sound_t      sound,
    output board_audio_pkg::led_bar_t    led_bar
);

    import board_audio_pkg::*;

    localparam sound_t sound_max = { 1'b0, { (w_sound - 1) { 1'b1 } } };
    localparam sound_t sound_min = { 1'b1, { (w_sound - 1) { 1'b0 } } };

    logic [1:0] key_meta;
    logic [1:0] key_sync;
    logic       gain;
    logic       mute;

    sound_t                   upper;
    logic signed [w_sound:0]  doubled;
    sound_t                   gained;
    sound_t                   sound_next;
    sound_t                   sound_neg;

    logic [w_sound - 2:0]     mag;
    logic [w_sound - 2:0]     peak;
    logic [w_sound - 2:0]     peak_next;

    //----------------------------------------------------------
    // Keys come from the board pins asynchronously

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= lab_key;
            key_sync <= key_meta;
        end
    end

    assign gain = key_sync [0];
    assign mute = key_sync [1];

    //----------------------------------------------------------
    // Gain, saturation and mute

    assign upper   = mic_value [w_mic_sample - 1 -: w_sound];
    assign doubled = { upper, 1'b0 };

    always_comb
    begin
        if (doubled [w_sound] == doubled [w_sound - 1])
            gained = doubled [w_sound - 1:0];
        else if (doubled [w_sound])
            gained = sound_min;  // Negative overflow
        else
            gained = sound_max;
    end

    always_comb
    begin
        if (mute)
            sound_next = '0;
        else if (gain)
            sound_next = gained;
        else
            sound_next = upper;
    end

    //----------------------------------------------------------
    // Peak magnitude since the last decay tick

    assign sound_neg = - sound_next;

    always_comb
    begin
        if (~ sound_next [w_sound - 1])
            mag = sound_next [w_sound - 2:0];
        else if (sound_next == sound_min)
            mag = '1;  // Clamp to 32767
        else
            mag = sound_neg [w_sound - 2:0];
    end

    always_comb
    begin
        if (mic_valid)
            peak_next = (decay_tick || mag > peak) ? mag : peak;
        else if (decay_tick)
            peak_next = '0;
        else
            peak_next = peak;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sound <= '0;
            peak  <= '0;
        end
        else
        begin
            if (mic_valid)
                sound <= sound_next;

            peak <= peak_next;
        end
    end

    // Thermometer, one LED per power of two
    always_comb
    begin
        for (int i = 0; i < led_bar_width; i ++)
            led_bar [i] = (peak >> (led_base_bit + i)) != '0;
    end

endmodule

/* logic/i2s_audio_out.sv */
`timescale 1ns/1ps

module i2s_audio_out
(
    input  logic                    clk,
    input  logic                    reset,
    input  board_audio_pkg::sound_t sound,

    output logic                    mclk,
    output logic                    bclk,
    output logic                    lrclk,
    output logic                    sdata
);

    import board_audio_pkg::*;

    //----------------------------------------------------------
    // Divider chain
    //   cnt [0] is mclk, then bclk, bit position, lrclk on top

    localparam int w_half = $clog2 (i2s_half_bit_clks);
    localparam int w_pos  = $clog2 (out_slot_bits);
    localparam int w_cnt  = w_half + 1 + w_pos + 1;

    logic [w_cnt - 1:0] cnt;
    logic [w_pos - 1:0] pos;

    logic bit_end;    // Next edge is a bclk fall
    logic frame_end;  // Next edge is an lrclk fall

    sound_t               word;
    logic [w_sound - 1:0] shreg;

    assign mclk  = cnt [0];
    assign bclk  = cnt [w_half];
    assign lrclk = cnt [w_cnt - 1];

    assign pos       = cnt [w_half + 1 +: w_pos];
    assign bit_end   = & cnt [w_half:0];
    assign frame_end = & cnt;

    //----------------------------------------------------------
    // Serializer
    // MSB goes out one bit after the lrclk edge, so the LSB
    // lands in the first bit time of the following slot

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt   <= '0;
            word  <= '0;
            shreg <= '0;
            sdata <= 1'b0;
        end
        else
        begin
            cnt <= cnt + 1'b1;

            if (frame_end)
                word <= sound;  // Same word for both slots

            if (bit_end)
            begin
                if (pos == '0)
                begin
                    sdata <= word [w_sound - 1];
                    shreg <= word << 1;
                end
                else
                begin
                    sdata <= shreg [w_sound - 1];
                    shreg <= shreg << 1;
                end
            end
        end
    end

endmodule

/* logic/board_top.sv */
`timescale 1ns/1ps

module board_top
#(
    parameter clk_mhz = 27,
              tick_hz = 2
)
(
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic [1:0]                             key,  // Active low
    output logic [board_audio_pkg::led_bar_width - 1:0] led,  // Active low

    output logic                                   mic_sck,
    output logic                                   mic_ws,
    output logic                                   mic_lr,
    input  logic                                   mic_sd,

    output logic                                   aud_mclk,
    output logic                                   aud_bclk,
    output logic                                   aud_lrclk,
    output logic                                   aud_sdata
);

    import board_audio_pkg::*;

    logic [1:0]  lab_key;
    led_bar_t    led_bar;

    mic_sample_t mic_value;
    logic        mic_valid;
    logic        decay_tick;
    sound_t      sound;

    //----------------------------------------------------------
    // Board buttons and LEDs are active low

    assign lab_key = ~ key;
    assign led     = ~ led_bar;

    assign mic_lr  = 1'b0;  // Microphone talks in the left slot

    //----------------------------------------------------------

    decay_strobe_gen
    #(
        .clk_mhz    ( clk_mhz    ),
        .tick_hz    ( tick_hz    )
    )
    i_decay_strobe_gen
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .decay_tick ( decay_tick )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk       ),
        .reset       ( reset     ),
        .sd          ( mic_sd    ),
        .sck         ( mic_sck   ),
        .ws          ( mic_ws    ),
        .value       ( mic_value ),
        .value_valid ( mic_valid )
    );

    level_meter_lab i_lab
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .lab_key    ( lab_key    ),
        .mic_value  ( mic_value  ),
        .mic_valid  ( mic_valid  ),
        .decay_tick ( decay_tick ),
        .sound      ( sound      ),
        .led_bar    ( led_bar    )
    );

    i2s_audio_out i_audio_out
    (
        .clk   ( clk       ),
        .reset ( reset     ),
        .sound ( sound     ),
        .mclk  ( aud_mclk  ),
        .bclk  ( aud_bclk  ),
        .lrclk ( aud_lrclk ),
        .sdata ( aud_sdata )
    );

endmodule

/* tests/board_top_tb.sv */
`timescale 1ns/1ps

module board_top_tb;

    import board_audio_pkg::*;

    logic       clk;
    logic       reset;
    logic [1:0] key;
    logic       mic_sd;
    logic [5:0] led;
    logic       mic_sck, mic_ws, mic_lr;
    logic       aud_mclk, aud_bclk, aud_lrclk, aud_sdata;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // Stimulus table from the data file
    int          ph_q   [$];
    logic [1:0]  key_q  [$];
    mic_sample_t word_q [$];
    sound_t      snd_q  [$];
    led_bar_t    bar_q  [$];

    mic_sample_t mic_words  [$];  // Words waiting for the microphone model
    sound_t      left_words [$];  // Decoded left slots

    board_top #(.clk_mhz (10), .tick_hz (200)) dut_i
    (
        .clk (clk), .reset (reset), .key (key), .led (led),
        .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_lr (mic_lr), .mic_sd (mic_sd),
        .aud_mclk (aud_mclk), .aud_bclk (aud_bclk),
        .aud_lrclk (aud_lrclk), .aud_sdata (aud_sdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~ clk;
    end

    //----------------------------------------------------------
    // Compare tasks

    task automatic check_sound (input string name, input sound_t got, input sound_t exp);
        if (got !== exp)
        begin
            $display ("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors ++;
        end
    endtask

    task automatic check_leds (input string name, input led_bar_t got, input led_bar_t exp);
        if (got !== exp)
        begin
            $display ("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors ++;
        end
    endtask

    task automatic check_pin (input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display ("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors ++;
        end
    endtask

    task automatic report_test (input string name, input int err_before);
        tests_run ++;
        if (errors != err_before)
            tests_failed ++;
        $display ("test %s: %s", name, errors == err_before ? "ok" : "errors");
    endtask

    //----------------------------------------------------------
    // Master clock at clk / 2 and the microphone channel strap

    logic mclk_exp;

    always @(posedge clk)
        mclk_exp <= reset ? 1'b0 : ~ mclk_exp;

    always @(negedge clk)
    begin
        if (! reset)
        begin
            check_pin ("aud_mclk", aud_mclk, mclk_exp);
            check_pin ("mic_lr", mic_lr, 1'b0);
        end
    end

    //----------------------------------------------------------
    // Microphone model driving left slot bits 1 to 24 MSB first

    int          mic_pos = 0;
    logic        prev_ws = 1'b0;
    mic_sample_t mic_cur = '0;

    always @(negedge mic_sck)
    begin
        #1;
        if (prev_ws && ! mic_ws)
            mic_pos = 0;  // New frame
        else
            mic_pos ++;
        prev_ws = mic_ws;

        if (! mic_ws && mic_pos == 1)
            mic_cur = mic_words.size () != 0 ? mic_words.pop_front () : '0;

        if (! mic_ws && mic_pos >= 1 && mic_pos <= w_mic_sample)
            mic_sd = mic_cur [w_mic_sample - mic_pos];
        else
            mic_sd = 1'b0;
    end

    //----------------------------------------------------------
    // Output decoder
    // LSB of a slot arrives in bit 0 of the next one

    logic   dec_lr    = 1'b0;
    logic   have_left = 1'b0;
    sound_t dec_acc   = '0;
    sound_t dec_word;
    sound_t last_left;

    always @(posedge aud_bclk)
    begin
        if (! reset)
        begin
            if (aud_lrclk != dec_lr)
            begin
                dec_word = { dec_acc [w_sound - 2:0], aud_sdata };
                if (! dec_lr)
                begin
                    left_words.push_back (dec_word);
                    last_left = dec_word;
                    have_left = 1'b1;
                end
                else if (have_left)
                    check_sound ("aud right word", dec_word, last_left);
                dec_lr = aud_lrclk;
            end
            else
                dec_acc = { dec_acc [w_sound - 2:0], aud_sdata };
        end
    end

    //----------------------------------------------------------
    // Waits with their own timeouts

    task automatic wait_decoded (output bit ok);
        int n = 0;
        while (left_words.size () == 0 && n < 1000)
        begin
            @(negedge clk);
            n ++;
        end
        ok = left_words.size () != 0;
        if (! ok)
        begin
            $display ("Timeout: no word decoded from the audio output");
            errors ++;
        end
    endtask

    task automatic wait_mic_done (input int words, output bit ok);
        int n = 0;
        while (mic_words.size () != 0 && n < (words + 2) * 512)
        begin
            @(negedge clk);
            n ++;
        end
        ok = mic_words.size () == 0;
        if (ok)
        begin
            n = 0;
            while (dut_i.mic_valid !== 1'b1 && n < 600)
            begin
                @(negedge clk);
                n ++;
            end
            ok = dut_i.mic_valid === 1'b1;
        end
        if (! ok)
        begin
            $display ("Timeout: the microphone receiver did not finish the phase");
            errors ++;
        end
    endtask

    // First lrclk fall after sound took the last sample latches it
    task automatic wait_last_word (output bit ok);
        int   n    = 0;
        int   decoded;
        logic lr_prev;
        bit   fell = 1'b0;

        @(negedge clk);
        lr_prev = aud_lrclk;
        while (! fell && n < 300)
        begin
            @(negedge clk);
            fell    = lr_prev && ! aud_lrclk;
            lr_prev = aud_lrclk;
            n ++;
        end
        decoded = left_words.size ();
        n       = 0;
        while (fell && left_words.size () == decoded && n < 300)
        begin
            @(negedge clk);
            n ++;
        end
        ok = fell && left_words.size () != decoded;
        if (! ok)
        begin
            $display ("Timeout: the last word of the phase never left the audio output");
            errors ++;
        end
    endtask

    task automatic wait_decay_tick (output bit ok);
        int n = 0;
        @(negedge clk);
        while (dut_i.decay_tick !== 1'b1 && n < 60000)
        begin
            @(negedge clk);
            n ++;
        end
        ok = dut_i.decay_tick === 1'b1;
        if (! ok)
        begin
            $display ("Timeout: no decay tick seen");
            errors ++;
        end
    endtask

    //----------------------------------------------------------
    // One phase of data-file lines with the same phase number

    task automatic run_phase (input int first, input int last);
        sound_t exp_list [$];
        sound_t got;
        int     idx  = 0;
        int     err0 = errors;
        bit     ok;

        wait_decay_tick (ok);
        repeat ($urandom_range (3, 0) * 512 + 1) @(posedge clk);  // Idle gap
        #1 key = ~ key_q [first];
        repeat (4) @(posedge clk);

        left_words.delete ();
        exp_list.push_back (sound_t' (0));
        for (int k = first; k < last; k ++)
        begin
            mic_words.push_back (word_q [k]);
            exp_list.push_back (snd_q [k]);
        end
        if (ok)
            wait_mic_done (last - first, ok);
        if (ok)
            wait_last_word (ok);

        // Each word is the current or the next expected value
        while (left_words.size () != 0)
        begin
            got = left_words.pop_front ();
            if (idx < exp_list.size () - 1 && got === exp_list [idx + 1])
                idx ++;
            else
                check_sound ("aud left word", got, exp_list [idx]);
        end
        if (ok && idx < exp_list.size () - 1)
        begin
            $display ("Decoded words never reached the last sample of phase %0d", ph_q [first]);
            errors ++;
        end

        @(negedge clk);
        check_leds ("led bar", led_bar_t' (~ led), bar_q [last - 1]);
        report_test ($sformatf ("phase %0d key %0d", ph_q [first], key_q [first]), err0);
    endtask

    //----------------------------------------------------------

    initial
    begin
        int     fd;
        int     ph, kv, i, j, err0, n;
        string  line;
        logic [23:0] w;
        logic [15:0] s;
        logic [5:0]  b;
        bit     ok;

        void' ($urandom (32'h28dc));
        reset  = 1'b1;
        key    = 2'b11;
        mic_sd = 1'b0;

        fd = $fopen ("tests/audio_input.txt", "r");
        if (fd == 0)
        begin
            $display ("Cannot open the stimulus file tests/audio_input.txt");
            errors ++;
        end
        else
        begin
            while (! $feof (fd))
            begin
                line = "";
                void' ($fgets (line, fd));
                if (line.len () > 1 && line [0] != "#"
                    && $sscanf (line, "%d %h %h %h %h", ph, kv, w, s, b) == 5)
                begin
                    ph_q.push_back (ph);
                    key_q.push_back (kv [1:0]);
                    word_q.push_back (w);
                    snd_q.push_back (s);
                    bar_q.push_back (b);
                end
            end
            $fclose (fd);
        end

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        // Reset state over two output frames
        err0 = errors;
        ok   = 1'b1;
        for (int f = 0; f < 2 && ok; f ++)
        begin
            wait_decoded (ok);
            if (ok)
                check_sound ("aud left word", left_words.pop_front (), sound_t' (0));
            check_leds ("led pins", led_bar_t' (led), '1);
        end
        report_test ("reset state", err0);

        i = 0;
        while (i < ph_q.size ())
        begin
            j = i;
            while (j < ph_q.size () && ph_q [j] == ph_q [i])
                j ++;
            run_phase (i, j);
            i = j;
        end

        // Silence until the peak decays away
        err0 = errors;
        n    = 0;
        while (led !== '1 && n < 60000)
        begin
            @(negedge clk);
            n ++;
        end
        if (led !== '1)
        begin
            $display ("Timeout: LED bar did not decay to dark");
            errors ++;
        end
        report_test ("decay", err0);

        $display ("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display ("Simulation completed successfully");
        else
            $display ("Simulation failed");
        $finish;
    end

endmodule

/* tests/audio_input.txt */
# phase  key(bit0 gain, bit1 mute)  mic word  expected sound  expected led bar
# All values hex except phase; led bar is the thermometer of the phase peak so far
1 0 0102ab 0102 00
1 0 ff00cd ff00 00
1 0 045011 0450 03
1 0 f80000 f800 07
1 0 00ff00 00ff 07
1 0 123456 1234 0f
2 0 7fffff 7fff 3f
2 0 800000 8000 3f
2 0 000000 0000 3f
3 1 100000 2000 1f
3 1 fff000 ffe0 1f
3 1 7fff00 7fff 3f
3 1 400000 7fff 3f
3 1 800000 8000 3f
3 1 c00000 8000 3f
3 1 c00100 8002 3f
4 1 020000 0400 03
4 1 fd0000 fa00 03
4 1 0001ff 0002 03
5 2 7fffff 0000 00
5 2 800000 0000 00
5 2 123456 0000 00
6 3 400000 0000 00
6 3 800000 0000 00
7 0 01ff00 01ff 00
7 0 0200ff 0200 01
7 0 fe0000 fe00 01
7 0 fdff00 fdff 01

/* board_audio.f */
logic/board_audio_pkg.sv
logic/decay_strobe_gen.sv
logic/inmp441_mic_i2s_receiver.sv
logic/level_meter_lab.sv
logic/i2s_audio_out.sv
logic/board_top.sv
tests/board_top_tb.sv

/* Bender.yml */
package:
  name: board_audio

sources:
  - files:
      - logic/board_audio_pkg.sv
      - logic/decay_strobe_gen.sv
      - logic/inmp441_mic_i2s_receiver.sv
      - logic/level_meter_lab.sv
      - logic/i2s_audio_out.sv
      - logic/board_top.sv
  - target: test
    files:
      - tests/board_top_tb.sv
